// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_daq_ctrl
FILELIST  := vlog.f
LOG       := sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs import daq_pkg::*;
(
    input  logic      bram_clk_a,
    input  logic      sys_rst_n_c,
    input  bram_req_t bram_req,
    input  logic      over_flow,          // live flag, shows in bit0 of offset 0
    input  logic      tirg_to_pcie,
    input  freq_t     ref_frequency,
    input  freq_t     measure_frequency,
    input  logic      rate_ready,
    output reg_data_t rd_data,
    output ctrl_cfg_t cfg,
    output logic      start_cmd,
    output logic      stop_cmd,
    output reg_data_t rate_word,
    output logic      rate_valid
);

    reg_data_t delay_time;
    reg_data_t cmd_reg;
    reg_data_t mode_reg;
    reg_data_t trig_reg;
    reg_data_t filter_reg;
    reg_data_t rate_reg;
    reg_data_t chan_reg;
    reg_data_t dir_reg;
    reg_data_t spare_reg;
    reg_data_t freq_mode_reg;
    reg_data_t sel_update_reg;
    reg_data_t phase_reg;

    logic       wr_word;   // full word write only
    logic       rd_req;
    logic [1:0] cmd_d;     // previous command bits

    assign wr_word = bram_req.en && (&bram_req.we);
    assign rd_req  = bram_req.en && (bram_req.we == '0);

    //////////////////////////////////////////////////////////////////////
    // write decode
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge bram_clk_a or negedge sys_rst_n_c)
    begin
        if (!sys_rst_n_c)
        begin
            delay_time     <= DELAY_RESET;
            cmd_reg        <= '0;
            mode_reg       <= '0;
            trig_reg       <= '0;
            filter_reg     <= '0;
            rate_reg       <= '0;
            chan_reg       <= '0;
            dir_reg        <= '0;
            spare_reg      <= '0;
            freq_mode_reg  <= '0;
            sel_update_reg <= SEL_UPDATE_RESET;
            phase_reg      <= '0;
        end
        else if (tirg_to_pcie)
            trig_reg <= 32'd1;                 // external trigger wins, write dropped
        else if (wr_word)
        begin
            case (bram_req.addr)
                REG_DELAY_OFS:      delay_time     <= bram_req.wdata;
                REG_CMD_OFS:        cmd_reg        <= bram_req.wdata;
                REG_MODE_OFS:       mode_reg       <= bram_req.wdata;
                REG_TRIG_OFS:       trig_reg       <= bram_req.wdata;
                REG_FILTER_OFS:     filter_reg     <= bram_req.wdata;
                REG_RATE_OFS:       rate_reg       <= bram_req.wdata;
                REG_CHAN_OFS:       chan_reg       <= bram_req.wdata;
                REG_DIR_OFS:        dir_reg        <= bram_req.wdata;
                REG_SPARE_OFS:      spare_reg      <= bram_req.wdata;
                REG_FREQ_MODE_OFS:  freq_mode_reg  <= bram_req.wdata;
                REG_SEL_UPDATE_OFS: sel_update_reg <= bram_req.wdata;
                REG_PHASE_OFS:      phase_reg      <= bram_req.wdata;
                default: ;                     // read only or unmapped
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered read mux, one cycle latency
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge bram_clk_a or negedge sys_rst_n_c)
    begin
        if (!sys_rst_n_c)
            rd_data <= '0;
        else if (rd_req)
        begin
            case (bram_req.addr)
                REG_DELAY_OFS:      rd_data <= {delay_time[DATA_W-1:1], over_flow};
                REG_CMD_OFS:        rd_data <= cmd_reg;
                REG_MODE_OFS:       rd_data <= mode_reg;
                REG_TRIG_OFS:       rd_data <= trig_reg;
                REG_FILTER_OFS:     rd_data <= filter_reg;
                REG_RATE_OFS:       rd_data <= rate_reg;
                REG_CHAN_OFS:       rd_data <= chan_reg;
                REG_DIR_OFS:        rd_data <= dir_reg;
                REG_SPARE_OFS:      rd_data <= spare_reg;
                REG_FREQ_MODE_OFS:  rd_data <= freq_mode_reg;
                REG_SEL_UPDATE_OFS: rd_data <= sel_update_reg;
                REG_PHASE_OFS:      rd_data <= phase_reg;
                REG_REF_FREQ_OFS:   rd_data <= {{(DATA_W-FREQ_W){1'b0}}, ref_frequency};
                REG_MEAS_FREQ_OFS:  rd_data <= {{(DATA_W-FREQ_W){1'b0}}, measure_frequency};
                default:            rd_data <= rd_data;   // unmapped, keep last
            endcase
        end
    end

    // static outputs straight from the bank
    assign cfg.test_mode         = mode_reg[0];
    assign cfg.adc_ch1_en        = chan_reg[0];
    assign cfg.adc_ch2_en        = chan_reg[1];
    assign cfg.alg_en            = chan_reg[2];
    assign cfg.back_board_dir    = dir_reg[0];
    assign cfg.phase_invert      = phase_reg[0];
    assign cfg.frequency_mode    = freq_mode_reg[1:0];
    assign cfg.select_dat_update = sel_update_reg;

    // command bit rising edges
    always_ff @(posedge bram_clk_a or negedge sys_rst_n_c)
    begin
        if (!sys_rst_n_c)
            cmd_d <= 2'b00;
        else
            cmd_d <= cmd_reg[1:0];
    end

    assign start_cmd = cmd_reg[1] && !cmd_d[1];
    assign stop_cmd  = cmd_reg[0] && !cmd_d[0];

    //////////////////////////////////////////////////////////////////////
    // sample rate offer towards word_sync
    //////////////////////////////////////////////////////////////////////
    // rate_word holds the offered word, then the last accepted one
    always_ff @(posedge bram_clk_a or negedge sys_rst_n_c)
    begin
        if (!sys_rst_n_c)
        begin
            rate_word  <= '0;
            rate_valid <= 1'b0;
        end
        else if (rate_valid)
        begin
            if (rate_ready)
                rate_valid <= 1'b0;             // taken by the crossing
        end
        else if (rate_reg != rate_word)
        begin
            rate_word  <= rate_reg;             // newer write goes out next
            rate_valid <= 1'b1;
        end
    end

endmodule

// File: daq_ctrl_top.sv
`timescale 1ns/1ps

module daq_ctrl_top import daq_pkg::*;
(
    input  logic      bram_clk_a,
    input  logic      adc_clk,
    input  logic      sys_rst_n_c,
    input  bram_req_t bram_req,
    input  logic      over_flow,
    input  logic      tirg_to_pcie,
    input  freq_t     ref_frequency,
    input  freq_t     measure_frequency,
    output reg_data_t rd_data,
    output ctrl_cfg_t cfg,
    output logic      start_sample,
    output logic      stop_sample,
    output logic      fifo_rst,
    output reg_data_t sample_rate_cfg_clk_adc
);

    logic      start_cmd;     // bram_clk_a pulses
    logic      stop_cmd;
    logic      start_pulse;   // adc_clk pulses
    logic      stop_pulse;
    reg_data_t rate_word;
    logic      rate_valid;
    logic      rate_ready;

    //////////////////////////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////////////////////////
    ctrl_regs u_regs
    (
        .bram_clk_a        (bram_clk_a),
        .sys_rst_n_c       (sys_rst_n_c),
        .bram_req          (bram_req),
        .over_flow         (over_flow),
        .tirg_to_pcie      (tirg_to_pcie),
        .ref_frequency     (ref_frequency),
        .measure_frequency (measure_frequency),
        .rate_ready        (rate_ready),
        .rd_data           (rd_data),
        .cfg               (cfg),
        .start_cmd         (start_cmd),
        .stop_cmd          (stop_cmd),
        .rate_word         (rate_word),
        .rate_valid        (rate_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // crossings into adc_clk
    //////////////////////////////////////////////////////////////////////
    pulse_sync u_start_sync
    (
        .bram_clk_a  (bram_clk_a),
        .adc_clk     (adc_clk),
        .sys_rst_n_c (sys_rst_n_c),
        .src_pulse   (start_cmd),
        .dst_pulse   (start_pulse)
    );

    pulse_sync u_stop_sync
    (
        .bram_clk_a  (bram_clk_a),
        .adc_clk     (adc_clk),
        .sys_rst_n_c (sys_rst_n_c),
        .src_pulse   (stop_cmd),
        .dst_pulse   (stop_pulse)
    );

    word_sync u_rate_sync   // sample rate word
    (
        .bram_clk_a  (bram_clk_a),
        .adc_clk     (adc_clk),
        .sys_rst_n_c (sys_rst_n_c),
        .src_word    (rate_word),
        .src_valid   (rate_valid),
        .src_ready   (rate_ready),
        .dst_word    (sample_rate_cfg_clk_adc)
    );

    // acquisition gate, adc_clk only
    sample_gate u_gate
    (
        .adc_clk      (adc_clk),
        .sys_rst_n_c  (sys_rst_n_c),
        .start_pulse  (start_pulse),
        .stop_pulse   (stop_pulse),
        .start_sample (start_sample),
        .stop_sample  (stop_sample),
        .fifo_rst     (fifo_rst)
    );

endmodule

// File: daq_pkg.sv
package daq_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths fixed by the host register map
    //////////////////////////////////////////////////////////////////////
    localparam int ADDR_W = 14;   // byte address on the bram port
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;    // one enable per byte lane
    localparam int FREQ_W = 24;   // frequency counter width

    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0] reg_data_t;
    typedef logic [BE_W-1:0]   byte_en_t;
    typedef logic [FREQ_W-1:0] freq_t;

    //////////////////////////////////////////////////////////////////////
    // register offsets, byte addressed
    //////////////////////////////////////////////////////////////////////
    localparam reg_addr_t REG_DELAY_OFS      = 14'd0;
    localparam reg_addr_t REG_CMD_OFS        = 14'd4;   // bit0 stop, bit1 start
    localparam reg_addr_t REG_MODE_OFS       = 14'd8;
    localparam reg_addr_t REG_TRIG_OFS       = 14'd12;
    localparam reg_addr_t REG_FILTER_OFS     = 14'd16;
    localparam reg_addr_t REG_RATE_OFS       = 14'd20;
    localparam reg_addr_t REG_CHAN_OFS       = 14'd24;  // ch1, ch2, alg
    localparam reg_addr_t REG_DIR_OFS        = 14'd28;
    localparam reg_addr_t REG_SPARE_OFS      = 14'd32;
    localparam reg_addr_t REG_FREQ_MODE_OFS  = 14'd36;
    localparam reg_addr_t REG_SEL_UPDATE_OFS = 14'd40;
    localparam reg_addr_t REG_PHASE_OFS      = 14'd44;
    localparam reg_addr_t REG_REF_FREQ_OFS   = 14'd48;  // read only
    localparam reg_addr_t REG_MEAS_FREQ_OFS  = 14'd52;  // read only

    localparam reg_data_t DELAY_RESET      = 32'd10;
    localparam reg_data_t SEL_UPDATE_RESET = 32'h7D0;

    // one host access, sampled on bram_clk_a
    typedef struct packed {
        logic      en;
        byte_en_t  we;
        reg_addr_t addr;
        reg_data_t wdata;
    } bram_req_t;

    // static config going out to the adc front end
    typedef struct packed {
        logic      test_mode;
        logic      adc_ch1_en;
        logic      adc_ch2_en;
        logic      alg_en;
        logic      back_board_dir;
        logic      phase_invert;
        logic [1:0] frequency_mode;
        reg_data_t select_dat_update;
    } ctrl_cfg_t;

    typedef enum logic {GATE_IDLE, GATE_SAMPLING} gate_state_t;
    typedef enum logic {XFER_IDLE, XFER_WAIT_ACK} xfer_state_t;

endpackage

// File: pulse_sync.sv
`timescale 1ns/1ps

// single pulse crossing, bram_clk_a to adc_clk
module pulse_sync
(
    input  logic bram_clk_a,
    input  logic adc_clk,
    input  logic sys_rst_n_c,
    input  logic src_pulse,
    output logic dst_pulse
);

    logic       src_tgl;     // flips once per source pulse
    logic [2:0] dst_sync;    // [1:0] synchronizer, [2] edge register

    always_ff @(posedge bram_clk_a or negedge sys_rst_n_c)
    begin
        if (!sys_rst_n_c)
            src_tgl <= 1'b0;
        else if (src_pulse)
            src_tgl <= ~src_tgl;
    end

    always_ff @(posedge adc_clk or negedge sys_rst_n_c)
    begin
        if (!sys_rst_n_c)
            dst_sync <= 3'b000;
        else
            dst_sync <= {dst_sync[1:0], src_tgl};
    end

    // any change of the synced toggle is one pulse
    assign dst_pulse = dst_sync[2] ^ dst_sync[1];

endmodule

// File: sample_gate.sv
`timescale 1ns/1ps

module sample_gate import daq_pkg::*;
(
    input  logic adc_clk,
    input  logic sys_rst_n_c,
    input  logic start_pulse,
    input  logic stop_pulse,
    output logic start_sample,
    output logic stop_sample,
    output logic fifo_rst
);

    gate_state_t state;
    gate_state_t state_nxt;
    logic        sampling_d;   // state one cycle back

    always_comb
    begin
        state_nxt = state;
        case (state)
            GATE_IDLE:
                if (start_pulse)
                    state_nxt = GATE_SAMPLING;
            GATE_SAMPLING:
                if (stop_pulse && !start_pulse)   // start has priority
                    state_nxt = GATE_IDLE;
            default:
                state_nxt = GATE_IDLE;
        endcase
    end

    always_ff @(posedge adc_clk or negedge sys_rst_n_c)
    begin
        if (!sys_rst_n_c)
        begin
            state      <= GATE_IDLE;
            sampling_d <= 1'b0;
            fifo_rst   <= 1'b0;
        end
        else
        begin
            state      <= state_nxt;
            sampling_d <= (state == GATE_SAMPLING);
            // falling edge of sampling, one clock late
            fifo_rst   <= sampling_d && (state == GATE_IDLE);
        end
    end

    assign start_sample = start_pulse;
    assign stop_sample  = stop_pulse;

endmodule

// File: tb_daq_ctrl.sv
`timescale 1ns/1ps

module tb_daq_ctrl import daq_pkg::*;
();

    localparam int      BRAM_HALF_NS = 4;       // 8 ns host clock
    localparam realtime ADC_HALF_NS  = 5.5;     // 11 ns adc clock
    // summed length of tests 1 to 6 in ns
    localparam int      TEST_NS      = 480 + 1760 + 80 + 400 + 740 + 480;
    localparam int      WATCHDOG_NS  = 2 * TEST_NS;

    logic      bram_clk_a;
    logic      adc_clk;
    logic      sys_rst_n_c;
    bram_req_t bram_req;
    logic      over_flow;
    logic      tirg_to_pcie;
    freq_t     ref_frequency;
    freq_t     measure_frequency;
    reg_data_t rd_data;
    ctrl_cfg_t cfg;
    logic      start_sample;
    logic      stop_sample;
    logic      fifo_rst;
    reg_data_t sample_rate_cfg_clk_adc;

    logic [31:0] lfsr = 32'h674afc6d;
    reg_data_t   model [12];              // writable bank by word index
    int          errors;
    int          checks;
    int          n_start = 0;             // pulses seen in adc_clk
    int          n_stop  = 0;
    int          n_fifo  = 0;

    daq_ctrl_top dut0 (.*);

    initial
    begin
        bram_clk_a = 1'b0;
        forever #(BRAM_HALF_NS) bram_clk_a = ~bram_clk_a;
    end

    initial
    begin
        adc_clk = 1'b0;
        forever #(ADC_HALF_NS) adc_clk = ~adc_clk;
    end

    // pulses counted on the falling adc edge
    always @(negedge adc_clk)
    begin
        if (sys_rst_n_c)
        begin
            n_start += int'(start_sample);
            n_stop  += int'(stop_sample);
            n_fifo  += int'(fifo_rst);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // random numbers and model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);  // galois step
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic reset_model();
        foreach (model[i])
            model[i] = '0;
        model[0]  = 32'd10;               // delay time
        model[10] = 32'h7D0;              // select_dat_update
    endtask

    function automatic ctrl_cfg_t cfg_expected();
        ctrl_cfg_t c;
        c.test_mode         = model[2][0];
        c.adc_ch1_en        = model[6][0];
        c.adc_ch2_en        = model[6][1];
        c.alg_en            = model[6][2];
        c.back_board_dir    = model[7][0];
        c.phase_invert      = model[11][0];
        c.frequency_mode    = model[9][1:0];
        c.select_dat_update = model[10];
        return c;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // host port access
    //////////////////////////////////////////////////////////////////////
    task automatic write_reg(input reg_addr_t addr, input reg_data_t data, input byte_en_t be,
                             input logic trig);
        @(posedge bram_clk_a);
        bram_req     <= '{en: 1'b1, we: be, addr: addr, wdata: data};
        tirg_to_pcie <= trig;
        @(posedge bram_clk_a);
        bram_req     <= '0;
        tirg_to_pcie <= 1'b0;
        if (trig)
            model[3] = 32'd1;             // trigger beats the write
        else if (be == 4'hF && addr[1:0] == 2'b00 && addr < 14'd48)
            model[addr[5:2]] = data;
    endtask

    // expected rd_data comes straight from the offset table
    task automatic read_check(input reg_addr_t addr, input reg_data_t exp, input logic ovf,
                              input string name);
        @(posedge bram_clk_a);
        bram_req  <= '{en: 1'b1, we: 4'h0, addr: addr, wdata: '0};
        over_flow <= ovf;
        @(posedge bram_clk_a);
        bram_req  <= '0;
        @(negedge bram_clk_a);            // rd_data settled
        check_val(name, 64'(rd_data), 64'(exp));
    endtask

    // live pulse count picked by sel (start, stop, fifo_rst)
    function automatic int pulse_count(input int sel);
        int c;
        case (sel)
            0:       c = n_start;
            1:       c = n_stop;
            default: c = n_fifo;
        endcase
        return c;
    endfunction

    task automatic wait_adc(input int target, input int sel, input string what);
        int k;
        k = 0;
        while (pulse_count(sel) < target && k < 6)
        begin
            @(negedge adc_clk);
            k++;
        end
        checks++;
        assert (pulse_count(sel) >= target)
        else
        begin
            errors++;
            $display("no %s pulse within 6 adc cycles", what);
        end
    endtask

    task automatic report(input int num, input string title, input int err_before);
        $display("test %0d %s: %s", num, title, (errors == err_before) ? "ok" : "errors");
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog ran out of time before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        int        e0;
        logic      ovf;
        reg_data_t d;
        reg_data_t last;
        byte_en_t  be;
        reg_addr_t a;
        freq_t     rf;
        freq_t     mf;

        sys_rst_n_c       = 1'b0;
        bram_req          = '0;
        over_flow         = 1'b0;
        tirg_to_pcie      = 1'b0;
        ref_frequency     = '0;
        measure_frequency = '0;
        errors            = 0;
        checks            = 0;
        reset_model();
        repeat (4) @(posedge bram_clk_a);
        sys_rst_n_c <= 1'b1;

        // 1. full word writes read back one by one
        e0 = errors;
        for (int i = 0; i < 12; i++)
        begin
            if (i == 1)
                continue;                 // command bits are test 5
            write_reg(reg_addr_t'(i * 4), rand_bits(32), 4'hF, 1'b0);
            ovf = 1'(rand_bits(1));
            d = (i == 0) ? {model[0][31:1], ovf} : model[i];
            read_check(reg_addr_t'(i * 4), d, ovf, "rd_data");
        end
        report(1, "word writes", e0);

        // 2. partial writes, unmapped reads, frequency readback
        e0 = errors;
        for (int n = 0; n < 20; n++)
        begin
            a  = reg_addr_t'((rand_bits(4) % 12) * 4);
            if (a == REG_CMD_OFS)
                a = REG_SPARE_OFS;
            be = byte_en_t'(rand_bits(4));
            if (be == 4'hF)
                be = 4'h7;
            if (be == 4'h0)
                be = 4'h1;                // zero enables would be a read
            write_reg(a, rand_bits(32), be, 1'b0);
            read_check(a, (a == 0) ? {model[0][31:1], 1'b0} : model[a[5:2]], 1'b0, "rd_data");
            d = rd_data;
            read_check(reg_addr_t'(56 + rand_bits(6) * 4), d, 1'b0, "rd_data unmapped");
            rf = freq_t'(rand_bits(24));
            mf = freq_t'(rand_bits(24));
            @(posedge bram_clk_a);
            ref_frequency     <= rf;
            measure_frequency <= mf;
            read_check(REG_REF_FREQ_OFS, {8'h00, rf}, 1'b0, "rd_data ref_freq");
            read_check(REG_MEAS_FREQ_OFS, {8'h00, mf}, 1'b0, "rd_data meas_freq");
        end
        report(2, "partial and read only", e0);

        // 3. trigger input wins over a write
        e0 = errors;
        write_reg(REG_TRIG_OFS, rand_bits(32) | 32'h2, 4'hF, 1'b1);
        read_check(REG_TRIG_OFS, 32'd1, 1'b0, "rd_data trig");
        report(3, "trigger latch", e0);

        // 4. cfg follows the bank and resets
        e0 = errors;
        for (int n = 0; n < 12; n++)
        begin
            case (rand_bits(3) % 6)
                0: a = REG_MODE_OFS;
                1: a = REG_CHAN_OFS;
                2: a = REG_DIR_OFS;
                3: a = REG_PHASE_OFS;
                4: a = REG_FREQ_MODE_OFS;
                default: a = REG_SEL_UPDATE_OFS;
            endcase
            write_reg(a, rand_bits(32), 4'hF, 1'b0);
            @(negedge bram_clk_a);
            check_val("cfg", 64'(cfg), 64'(cfg_expected()));
        end
        @(posedge bram_clk_a);
        sys_rst_n_c <= 1'b0;
        repeat (4) @(posedge bram_clk_a);
        sys_rst_n_c <= 1'b1;
        reset_model();
        @(negedge bram_clk_a);
        check_val("cfg after reset", 64'(cfg), 64'(cfg_expected()));
        check_val("sample_rate_cfg_clk_adc", 64'(sample_rate_cfg_clk_adc), 64'h0);
        report(4, "cfg outputs", e0);

        // 5. start and stop commands through the gate
        e0 = errors;
        for (int r = 1; r <= 3; r++)
        begin
            write_reg(REG_CMD_OFS, 32'h2, 4'hF, 1'b0);    // start rises
            wait_adc(r, 0, "start_sample");
            repeat (2) @(negedge adc_clk);
            write_reg(REG_CMD_OFS, 32'h1, 4'hF, 1'b0);    // stop rises
            wait_adc(r, 1, "stop_sample");
            wait_adc(r, 2, "fifo_rst");
            write_reg(REG_CMD_OFS, 32'h0, 4'hF, 1'b0);
            repeat (6) @(negedge adc_clk);
        end
        check_val("start_sample count", 64'(n_start), 64'(3));
        check_val("stop_sample count", 64'(n_stop), 64'(3));
        check_val("fifo_rst count", 64'(n_fifo), 64'(3));
        report(5, "command pulses", e0);

        // 6. last word of a rate burst lands and stays
        e0 = errors;
        last = '0;
        for (int n = 0; n < 8; n++)
        begin
            last = rand_bits(32);
            write_reg(REG_RATE_OFS, last, 4'hF, 1'b0);
        end
        for (int k = 0; k < 12 && sample_rate_cfg_clk_adc !== last; k++)
            @(negedge adc_clk);
        check_val("sample_rate_cfg_clk_adc", 64'(sample_rate_cfg_clk_adc), 64'(last));
        repeat (20) @(negedge adc_clk);
        check_val("sample_rate_cfg_clk_adc hold", 64'(sample_rate_cfg_clk_adc), 64'(last));
        report(6, "rate crossing", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: tb_daq_ctrl_sva.sv
`timescale 1ns/1ps

module tb_daq_ctrl_sva import daq_pkg::*;
(
    input logic      bram_clk_a,
    input logic      adc_clk,
    input logic      sys_rst_n_c,
    input bram_req_t bram_req,
    input reg_data_t rd_data,
    input logic      start_sample,
    input logic      stop_sample,
    input logic      fifo_rst
);

    logic seen_stop;   // stop seen since the last fifo_rst

    always_ff @(posedge adc_clk or negedge sys_rst_n_c)
    begin
        if (!sys_rst_n_c)
            seen_stop <= 1'b0;
        else if (stop_sample)
            seen_stop <= 1'b1;
        else if (fifo_rst)
            seen_stop <= 1'b0;   // each fifo_rst uses up one stop
    end

    //////////////////////////////////////////////////////////////////////
    // adc side pulses
    //////////////////////////////////////////////////////////////////////
    a_start_one: assert property (@(posedge adc_clk) disable iff (!sys_rst_n_c)
        start_sample |=> !start_sample) else $error("start_sample wider than one cycle");
    a_stop_one: assert property (@(posedge adc_clk) disable iff (!sys_rst_n_c)
        stop_sample |=> !stop_sample) else $error("stop_sample wider than one cycle");
    a_fifo_one: assert property (@(posedge adc_clk) disable iff (!sys_rst_n_c)
        fifo_rst |=> !fifo_rst) else $error("fifo_rst wider than one cycle");
    a_fifo_after_stop: assert property (@(posedge adc_clk) disable iff (!sys_rst_n_c)
        fifo_rst |-> seen_stop) else $error("fifo_rst without an earlier stop");

    // read data only moves after a read
    a_rd_hold: assert property (@(posedge bram_clk_a) disable iff (!sys_rst_n_c)
        !$past(bram_req.en && bram_req.we == 4'h0) |-> $stable(rd_data))
        else $error("rd_data changed without a read");

endmodule

bind daq_ctrl_top tb_daq_ctrl_sva sva0 (.*);

// File: vlog.f
daq_pkg.sv
ctrl_regs.sv
pulse_sync.sv
word_sync.sv
sample_gate.sv
daq_ctrl_top.sv
tb_daq_ctrl_sva.sv
tb_daq_ctrl.sv

// File: word_sync.sv
`timescale 1ns/1ps

module word_sync import daq_pkg::*;
(
    input  logic      bram_clk_a,
    input  logic      adc_clk,
    input  logic      sys_rst_n_c,
    input  reg_data_t src_word,
    input  logic      src_valid,
    output logic      src_ready,
    output reg_data_t dst_word
);

    xfer_state_t state;
    reg_data_t   word_hold;    // stable while a request is in flight
    logic        req_tgl;
    logic [1:0]  ack_sync;     // ack toggle seen in bram_clk_a
    logic [1:0]  req_sync;     // req toggle seen in adc_clk
    logic        ack_tgl;      // also remembers the last request served

    //////////////////////////////////////////////////////////////////////
    // source side in bram_clk_a
    //////////////////////////////////////////////////////////////////////
    assign src_ready = (state == XFER_IDLE);

    always_ff @(posedge bram_clk_a or negedge sys_rst_n_c)
    begin
        if (!sys_rst_n_c)
        begin
            state    <= XFER_IDLE;
            req_tgl  <= 1'b0;
            ack_sync <= 2'b00;
        end
        else
        begin
            ack_sync <= {ack_sync[0], ack_tgl};
            case (state)
                XFER_IDLE:
                    if (src_valid)
                    begin
                        req_tgl <= ~req_tgl;   // new request
                        state   <= XFER_WAIT_ACK;
                    end
                XFER_WAIT_ACK:
                    if (ack_sync[1] == req_tgl)
                        state <= XFER_IDLE;    // far side has the word
                default:
                    state <= XFER_IDLE;
            endcase
        end
    end

    // payload captured on acceptance
    always_ff @(posedge bram_clk_a or negedge sys_rst_n_c)
    begin
        if (!sys_rst_n_c)
            word_hold <= '0;
        else if (src_valid && src_ready)
            word_hold <= src_word;
    end

    //////////////////////////////////////////////////////////////////////
    // destination side in adc_clk
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge adc_clk or negedge sys_rst_n_c)
    begin
        if (!sys_rst_n_c)
        begin
            req_sync <= 2'b00;
            ack_tgl  <= 1'b0;
            dst_word <= '0;
        end
        else
        begin
            req_sync <= {req_sync[0], req_tgl};
            if (req_sync[1] != ack_tgl)
            begin
                dst_word <= word_hold;         // hold is quiet by now
                ack_tgl  <= req_sync[1];
            end
        end
    end

endmodule
